/* include/cart_defs.svh */
// Cartridge slot constants for address widths, ROM depth and I/O ports
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// Width of a translated ROM byte address as the mapper hands it to memory
`define CART_ADDR_W 27

// Depth of the cartridge ROM array in bytes (64 KB)
`define CART_ROM_BYTES 65536

// I/O port that sets the mapper type and the bank-table entry
`define CART_CFG_PORT_MAP 8'h5C

// I/O port that sets the ROM size, counted in 16 KB pages
`define CART_CFG_PORT_SIZE 8'h5D

// Offset bits inside one 16 KB CPU page
// The page number sits in the address bits above these
`define CART_PAGE_BITS 14

`endif

/* design/cart_pkg.sv */
// Cartridge slot package with the mapper type and block configuration types
`default_nettype none

package cart_pkg;

    // Mapper types this slot knows about
    // Only the CrossBlaim mapper is built here, everything else reads as none
    typedef enum logic [1:0] {
        MAPPER_NONE        = 2'd0,
        MAPPER_CROSS_BLAIM = 2'd1
    } mapper_typ_t;

    // Configuration of one cartridge block
    // The config registers own it and the mapper only reads it
    typedef struct packed {
        // Which mapper steers the slot
        mapper_typ_t typ;

        // Bank-table entry in use
        // The mapper keeps one table per entry, so switching back restores the old layout
        logic        id;

        // Size of the loaded ROM in bytes
        // Accesses at or above this size are treated as unmapped
        logic [24:0] rom_size;
    } block_info_t;

endpackage

`default_nettype wire

/* design/cpu_bus_if.sv */
// CPU bus interface bundling the clock, reset, address, data and cycle strobes
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

    // Bus clock and asynchronous active-low reset
    logic        cpu_bus;
    logic        arst_n;

    // Address and write data of the current cycle
    logic [15:0] addr;
    logic [7:0]  data;

    // Memory or I/O cycle
    logic        mreq;
    logic        iorq;

    // Direction of the cycle
    logic        rd;
    logic        wr;

    // One-cycle strobe that marks when a cycle actually happens
    // Levels above are only sampled while this is high
    logic        req;

    // The slot top level drives the bus
    modport host (output cpu_bus, arst_n, addr, data, mreq, iorq, rd, wr, req);

    // Config registers, mapper and ROM port listen to it
    modport device (input cpu_bus, arst_n, addr, data, mreq, iorq, rd, wr, req);

endinterface

`default_nettype wire

/* design/mapper_out_if.sv */
// Mapper output interface carrying the ROM select and translated byte address
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

interface mapper_out_if;

    // High when the current CPU read hits mapped ROM
    logic                    ram_cs;

    // ROM byte address, all ones whenever ram_cs is low
    logic [`CART_ADDR_W-1:0] addr;

    // Driven by the mapper
    modport mapper (output ram_cs, addr);

    // Consumed by the ROM port
    modport memory (input ram_cs, addr);

endinterface

`default_nettype wire

/* design/cart_config_regs.sv */
// Cartridge configuration registers written by I/O cycles to set up the mapper
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_config_regs (
    cpu_bus_if.device             cpu_bus,
    output cart_pkg::block_info_t block_info
);

    import cart_pkg::*;

    // Width of the byte-count field in the configuration
    localparam int SIZE_W = $bits(block_info.rom_size);

    // Any I/O write cycle on the bus
    logic              io_wr;

    // Writes that hit one of the two configuration ports
    logic              map_wr;
    logic              size_wr;

    // Size write converted from pages to bytes
    logic [SIZE_W-1:0] size_bytes;

    // An I/O write needs the strobe, otherwise the levels are just idle bus state
    assign io_wr = cpu_bus.iorq & cpu_bus.wr & cpu_bus.req;

    // Only the low address byte selects the I/O port, as on the real bus
    assign map_wr  = io_wr & (cpu_bus.addr[7:0] == `CART_CFG_PORT_MAP);
    assign size_wr = io_wr & (cpu_bus.addr[7:0] == `CART_CFG_PORT_SIZE);

    // The size port counts 16 KB pages
    // Shifting by the page offset width turns that into bytes
    assign size_bytes = SIZE_W'(cpu_bus.data) << `CART_PAGE_BITS;

    // Mapper control register
    // Bit 0 turns CrossBlaim on, bit 4 picks the bank-table entry
    always_ff @(posedge cpu_bus.cpu_bus or negedge cpu_bus.arst_n) begin
        if (!cpu_bus.arst_n) begin
            block_info.typ <= MAPPER_NONE;
            block_info.id  <= 1'b0;
        end else if (map_wr) begin
            block_info.typ <= cpu_bus.data[0] ? MAPPER_CROSS_BLAIM : MAPPER_NONE;
            block_info.id  <= cpu_bus.data[4];
        end
    end

    // ROM size register
    // A size of zero keeps every read unmapped until software sets it
    always_ff @(posedge cpu_bus.cpu_bus or negedge cpu_bus.arst_n) begin
        if (!cpu_bus.arst_n) begin
            block_info.rom_size <= '0;
        end else if (size_wr) begin
            block_info.rom_size <= size_bytes;
        end
    end

    // Both registers update on the edge after the write strobe.
    // The mapper sees the new values in the very next cycle

endmodule

`default_nettype wire

/* design/mapper_crossblaim.sv */
// CrossBlaim bank mapper with two bank tables and combinational address translation
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module mapper_cross_blaim (
    cpu_bus_if.device             cpu_bus,
    input  cart_pkg::block_info_t block_info,
    mapper_out_if.mapper          out
);

    import cart_pkg::*;

    localparam int ADDR_W = `CART_ADDR_W;

    // Each page entry is {unmapped, bank[1:0]}
    // One table of four pages per bank-table entry
    logic [3:0][2:0]   bank_tbl [2];

    logic              enabled;
    logic              map_wr;
    logic [1:0]        page;
    logic [2:0]        page_entry;
    logic              unmapped;
    logic [1:0]        bank;
    logic [ADDR_W-1:0] rom_addr;
    logic              in_range;
    logic              hit;

    // Page layout chosen by the low two bits of a mapper write
    // Packed order is page 3 first, page 0 last
    function automatic logic [3:0][2:0] page_layout(input logic [1:0] sel);
        logic [3:0][2:0] lay;
        case (sel)
            // Page 0 and 3 drop out, page 2 gets bank 2 or 3
            2'd2:    lay = {3'b100, 3'b010, 3'b000, 3'b100};
            2'd3:    lay = {3'b100, 3'b011, 3'b000, 3'b100};
            // Power-on layout, also used for data 0 and 1
            default: lay = {3'b001, 3'b001, 3'b000, 3'b001};
        endcase
        return lay;
    endfunction

    assign enabled = (block_info.typ == MAPPER_CROSS_BLAIM);

    // The mapper register decodes no address, any memory write hits it
    assign map_wr = enabled & cpu_bus.mreq & cpu_bus.wr & cpu_bus.req;

    // Only the entry picked by id changes, the other one keeps its layout
    always_ff @(posedge cpu_bus.cpu_bus or negedge cpu_bus.arst_n) begin
        if (!cpu_bus.arst_n) begin
            bank_tbl[0] <= page_layout(2'd0);
            bank_tbl[1] <= page_layout(2'd0);
        end else if (map_wr) begin
            bank_tbl[block_info.id] <= page_layout(cpu_bus.data[1:0]);
        end
    end

    // Top two address bits select the 16 KB page
    assign page       = cpu_bus.addr[15:`CART_PAGE_BITS];
    assign page_entry = bank_tbl[block_info.id][page];
    assign {unmapped, bank} = page_entry;

    // Bank number lands directly above the page offset
    assign rom_addr = ADDR_W'({bank, cpu_bus.addr[`CART_PAGE_BITS-1:0]});
    assign in_range = rom_addr < ADDR_W'(block_info.rom_size);

    // Select needs a memory read on a mapped page inside the loaded ROM
    assign hit = enabled & cpu_bus.mreq & cpu_bus.rd & ~unmapped & in_range;

    assign out.ram_cs = hit;
    assign out.addr   = hit ? rom_addr : '1;

endmodule

`default_nettype wire

/* design/cart_rom_port.sv */
// Cartridge ROM with a download write port and a registered one-cycle CPU read
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_rom_port (
    cpu_bus_if.device    cpu_bus,
    mapper_out_if.memory map,
    input  logic         load_en,
    input  logic [15:0]  load_addr,
    input  logic [7:0]   load_data,
    output logic [7:0]   rd_data,
    output logic         rd_valid
);

    // Address bits needed to index the whole array
    localparam int ROM_AW = $clog2(`CART_ROM_BYTES);

    // Cartridge image, filled by the download port before the CPU runs
    logic [7:0]        rom [`CART_ROM_BYTES];

    // A memory read cycle that needs exactly one answer
    logic              rd_stb;
    logic [ROM_AW-1:0] rom_idx;

    assign rd_stb = cpu_bus.mreq & cpu_bus.rd & cpu_bus.req;

    // The mapper never selects above 64 KB, so the low bits are the index
    assign rom_idx = map.addr[ROM_AW-1:0];

    // Download port
    // Each load_en write lands on the next edge
    always_ff @(posedge cpu_bus.cpu_bus) begin
        if (load_en) begin
            rom[load_addr] <= load_data;
        end
    end

    // Read data is captured at the strobe.
    // Unselected reads return an open bus, which floats high on MSX
    always_ff @(posedge cpu_bus.cpu_bus) begin
        if (rd_stb) begin
            rd_data <= map.ram_cs ? rom[rom_idx] : 8'hFF;
        end
    end

    // One valid pulse per strobe, one cycle later
    // Back-to-back strobes give back-to-back pulses
    always_ff @(posedge cpu_bus.cpu_bus or negedge cpu_bus.arst_n) begin
        if (!cpu_bus.arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_stb;
        end
    end

endmodule

`default_nettype wire

/* design/cart_slot_top.sv */
// Cartridge slot top level connecting config registers, CrossBlaim mapper and ROM
`timescale 1ns/1ps
`default_nettype none

module cart_slot_top (
    // Bus clock and asynchronous active-low reset
    input  logic        cpu_bus,
    input  logic        arst_n,

    // CPU bus cycle
    input  logic [15:0] addr,
    input  logic [7:0]  data,
    input  logic        mreq,
    input  logic        iorq,
    input  logic        rd,
    input  logic        wr,
    input  logic        req,

    // ROM download port
    input  logic        load_en,
    input  logic [15:0] load_addr,
    input  logic [7:0]  load_data,

    // Read response, one cycle after the strobe
    output logic [7:0]  rd_data,
    output logic        rd_valid
);

    import cart_pkg::*;

    // Configuration passed from the registers to the mapper
    block_info_t block_info;

    // Bus bundle shared by all devices in the slot
    cpu_bus_if bus_if ();

    // Mapper result towards the ROM
    mapper_out_if map_if ();

    // The top level acts as bus host.
    // Plain ports go straight onto the interface
    assign bus_if.cpu_bus = cpu_bus;
    assign bus_if.arst_n  = arst_n;
    assign bus_if.addr    = addr;
    assign bus_if.data    = data;
    assign bus_if.mreq    = mreq;
    assign bus_if.iorq    = iorq;
    assign bus_if.rd      = rd;
    assign bus_if.wr      = wr;
    assign bus_if.req     = req;

    // I/O ports for mapper type, table entry and ROM size
    cart_config_regs u_config_regs (
        .cpu_bus    (bus_if.device),
        .block_info (block_info)
    );

    // Translates CPU addresses and keeps the bank tables
    mapper_cross_blaim u_mapper (
        .cpu_bus    (bus_if.device),
        .block_info (block_info),
        .out        (map_if.mapper)
    );

    // ROM array and read response
    // Download writes and CPU reads share the bus clock
    cart_rom_port u_rom_port (
        .cpu_bus   (bus_if.device),
        .map       (map_if.memory),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

/* dv/cart_slot_tb.sv */
// Cartridge slot testbench with a CrossBlaim reference model and read checks
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_slot_tb;

    localparam int RESET_CYCLES = 8;
    localparam int ROM_BYTES    = `CART_ROM_BYTES;
    localparam int PAGE_BYTES   = 1 << `CART_PAGE_BITS;
    localparam int MIX_OPS      = 3000;
    // The tests after the download take under 5000 cycles, so this leaves ample margin
    localparam int TEST_BUDGET  = 14456;
    localparam int MAX_CYCLES   = RESET_CYCLES + ROM_BYTES + TEST_BUDGET;
    localparam int DRAIN_LIMIT  = 8;

    logic        cpu_bus;
    logic        arst_n;
    logic [15:0] addr;
    logic [7:0]  data;
    logic        mreq, iorq, rd, wr, req;
    logic        load_en;
    logic [15:0] load_addr;
    logic [7:0]  load_data;
    logic [7:0]  rd_data;
    logic        rd_valid;

    // Copy of the downloaded image and the queue of predicted read data
    logic [7:0]  rom_copy [ROM_BYTES];
    logic [7:0]  exp_q [$];

    // Reference model of the configuration and the two bank tables
    bit          mdl_en;
    int          mdl_id;
    int          mdl_size;
    bit          mdl_unmapped [2][4];
    int          mdl_bank [2][4];

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    bit          prev_rd_stb;
    logic [31:0] seed_ret;

    cart_slot_top uut (
        .cpu_bus   (cpu_bus),
        .arst_n    (arst_n),
        .addr      (addr),
        .data      (data),
        .mreq      (mreq),
        .iorq      (iorq),
        .rd        (rd),
        .wr        (wr),
        .req       (req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #2 cpu_bus = ~cpu_bus;
    end

    always @(posedge cpu_bus) cycles <= cycles + 1;

    // Watchdog in case the DUT or a wait loop stalls
    initial begin
        while (cycles < MAX_CYCLES) @(posedge cpu_bus);
        $display("timeout after %0d cycles, the run did not finish", cycles);
        $display("Done: errors found");
        $finish;
    end

    // Responses are checked mid-cycle, where the DUT outputs are settled
    always @(negedge cpu_bus) begin
        if (arst_n) begin
            assert (rd_valid == prev_rd_stb) else begin
                $display("read response pulse at %0t ns is out of step with the strobe", $time);
                errors = errors + 1;
            end
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    $display("rd_valid at %0t ns came with no read outstanding", $time);
                    errors = errors + 1;
                end else begin
                    checks = checks + 1;
                    assert (rd_data === exp_q[0]) else begin
                        $display("mismatch at %0t ns: read data %02h, expected %02h",
                                 $time, rd_data, exp_q[0]);
                        errors = errors + 1;
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
        prev_rd_stb = mreq & rd & req;
    end

    // Page layouts as the CrossBlaim mapper defines them
    task automatic set_page(input int tbl, input int page, input bit unm, input int bank);
        mdl_unmapped[tbl][page] = unm;
        mdl_bank[tbl][page]     = bank;
    endtask

    task automatic set_layout(input int tbl, input logic [1:0] sel);
        if (sel == 2'd2 || sel == 2'd3) begin
            set_page(tbl, 0, 1'b1, 0);
            set_page(tbl, 1, 1'b0, 0);
            set_page(tbl, 2, 1'b0, int'(sel));
            set_page(tbl, 3, 1'b1, 0);
        end else begin
            set_page(tbl, 0, 1'b0, 1);
            set_page(tbl, 1, 1'b0, 0);
            set_page(tbl, 2, 1'b0, 1);
            set_page(tbl, 3, 1'b0, 1);
        end
    endtask

    function automatic logic [7:0] predict_read(input logic [15:0] a);
        int page;
        int byte_addr;
        page = int'(a[15:14]);
        if (!mdl_en) return 8'hFF;
        if (mdl_unmapped[mdl_id][page]) return 8'hFF;
        byte_addr = mdl_bank[mdl_id][page] * PAGE_BYTES + int'(a[13:0]);
        if (byte_addr >= mdl_size) return 8'hFF;
        return rom_copy[byte_addr];
    endfunction

    task automatic drive_cycle(input bit io, input bit write, input logic [15:0] a,
                               input logic [7:0] d);
        @(posedge cpu_bus);
        addr <= a;
        data <= d;
        mreq <= !io;
        iorq <= io;
        rd   <= !write;
        wr   <= write;
        req  <= 1'b1;
    endtask

    task automatic drive_idle();
        @(posedge cpu_bus);
        mreq <= 1'b0;
        iorq <= 1'b0;
        rd   <= 1'b0;
        wr   <= 1'b0;
        req  <= 1'b0;
    endtask

    task automatic cpu_read(input logic [15:0] a);
        exp_q.push_back(predict_read(a));
        drive_cycle(1'b0, 1'b0, a, 8'h00);
    endtask

    // One read at a random offset in each of the four pages
    task automatic read_pages();
        for (int p = 0; p < 4; p++) begin
            cpu_read({2'(p), 14'($urandom)});
        end
    endtask

    task automatic mapper_write(input logic [7:0] d);
        drive_cycle(1'b0, 1'b1, 16'($urandom), d);
        if (mdl_en) set_layout(mdl_id, d[1:0]);
    endtask

    task automatic config_map(input bit en, input bit id);
        drive_cycle(1'b1, 1'b1, {8'($urandom), `CART_CFG_PORT_MAP}, {3'b000, id, 3'b000, en});
        mdl_en = en;
        mdl_id = int'(id);
    endtask

    task automatic config_size(input int pages);
        drive_cycle(1'b1, 1'b1, {8'($urandom), `CART_CFG_PORT_SIZE}, 8'(pages));
        mdl_size = pages * PAGE_BYTES;
    endtask

    // Let outstanding reads come back, with a bound on the wait
    task automatic wait_responses();
        int waited;
        waited = 0;
        drive_idle();
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge cpu_bus);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d read responses never arrived by %0t ns", exp_q.size(), $time);
            errors = errors + 1;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        wait_responses();
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - err_before);
        end
    endtask

    initial begin
        int err0;
        int r;
        logic [7:0] b;

        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        prev_rd_stb = 1'b0;
        seed_ret = $urandom(32'h39ac);
        arst_n = 1'b0;
        addr = '0;
        data = '0;
        mreq = 1'b0;
        iorq = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        req = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        mdl_en = 1'b0;
        mdl_id = 0;
        mdl_size = 0;
        set_layout(0, 2'd0);
        set_layout(1, 2'd0);

        repeat (RESET_CYCLES) @(posedge cpu_bus);
        arst_n <= 1'b1;

        // Download a random image and keep the copy for the model
        for (int i = 0; i < ROM_BYTES; i++) begin
            b = 8'($urandom);
            rom_copy[i] = b;
            @(posedge cpu_bus);
            load_en   <= 1'b1;
            load_addr <= 16'(i);
            load_data <= b;
        end
        @(posedge cpu_bus);
        load_en <= 1'b0;

        err0 = errors;
        repeat (4) read_pages();
        end_test("after_reset", err0);

        err0 = errors;
        config_size(4);
        config_map(1'b1, 1'b0);
        repeat (4) read_pages();
        end_test("default_tables", err0);

        err0 = errors;
        mapper_write(8'h02);
        repeat (3) read_pages();
        mapper_write(8'h03);
        repeat (3) read_pages();
        mapper_write(8'h00);
        repeat (3) read_pages();
        end_test("bank_switching", err0);

        err0 = errors;
        config_size(2);
        mapper_write(8'h02);
        repeat (3) read_pages();
        mapper_write(8'h03);
        repeat (3) read_pages();
        mapper_write(8'h01);
        repeat (3) read_pages();
        config_size(4);
        end_test("size_limit", err0);

        err0 = errors;
        config_map(1'b1, 1'b0);
        mapper_write(8'h02);
        config_map(1'b1, 1'b1);
        mapper_write(8'h03);
        read_pages();
        config_map(1'b1, 1'b0);
        read_pages();
        for (int i = 0; i < 20; i++) begin
            config_map(1'b1, 1'($urandom));
            mapper_write(8'($urandom));
            read_pages();
            config_map(1'b1, 1'(mdl_id == 0));
            read_pages();
        end
        end_test("independent_tables", err0);

        err0 = errors;
        for (int i = 0; i < MIX_OPS; i++) begin
            r = int'($urandom_range(0, 99));
            if (r < 70) begin
                cpu_read(16'($urandom));
            end else if (r < 82) begin
                mapper_write(8'($urandom));
            end else if (r < 90) begin
                config_map(1'($urandom_range(0, 9) != 0), 1'($urandom));
            end else if (r < 95) begin
                config_size(int'($urandom_range(0, 4)));
            end else begin
                drive_idle();
            end
        end
        end_test("random_mix", err0);

        $display("tests run %0d, tests failed %0d, reads checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
design/cart_pkg.sv
design/cpu_bus_if.sv
design/mapper_out_if.sv
design/cart_config_regs.sv
design/mapper_crossblaim.sv
design/cart_rom_port.sv
design/cart_slot_top.sv
dv/cart_slot_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cartridge slot testbench with Verilator, run it and judge the log
verilator --binary --assert -Wno-fatal -f compile.f --top-module cart_slot_tb \
    -Mdir obj_dir -o cart_slot_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cart_slot_sim > sim.log 2>&1 \
    || { echo "simulation exited abnormally, see sim.log"; exit 1; }
grep -q "Done: errors found" sim.log \
    && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log \
    || { echo "no result line in sim.log"; exit 1; }
echo "PASS"
